// File: hw/glyph_rom.sv
`default_nettype none
`timescale 1ns/1ps

module glyph_rom import panel_pkg::*; (
    input  frame_id_t        frame,
    input  logic [2:0]       row_index,
    output logic [COLS-1:0]  glyph
);

    always_comb
    begin
        glyph = '0; // rows not listed stay dark
        case (frame)
            FLAME_0:
            begin
                case (row_index)
                    3'd2, 3'd5: glyph = 8'b0001_1000;
                    3'd3, 3'd4: glyph = 8'b0011_1100;
                    default:    glyph = 8'b0000_0000;
                endcase
            end
            FLAME_1:
            begin
                case (row_index)
                    3'd2, 3'd5: glyph = 8'b0011_1000;
                    3'd3, 3'd4: glyph = 8'b0111_1100;
                    default:    glyph = 8'b0000_0000;
                endcase
            end
            FLAME_2:
            begin
                case (row_index)
                    3'd2, 3'd5: glyph = 8'b0011_1100;
                    3'd3, 3'd4: glyph = 8'b0111_1110;
                    default:    glyph = 8'b0000_0000;
                endcase
            end
            FLAME_3:
            begin
                case (row_index)
                    3'd1, 3'd6:             glyph = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: glyph = 8'b0111_1110;
                    default:                glyph = 8'b0000_0000;
                endcase
            end
            FLAME_4:
            begin
                case (row_index)
                    3'd0, 3'd7: glyph = 8'b0011_1100;
                    3'd1, 3'd6: glyph = 8'b0111_1110;
                    default:    glyph = 8'b1111_1111; // rows 2..5 solid
                endcase
            end
            FLAME_FULL:
            begin
                glyph = 8'b1111_1111;
            end
            FAN:
            begin
                case (row_index)
                    3'd0: glyph = 8'b1100_0011;
                    3'd1: glyph = 8'b1110_0011;
                    3'd2: glyph = 8'b1111_0001;
                    3'd3: glyph = 8'b1110_0011;
                    3'd4: glyph = 8'b1100_0111;
                    3'd5: glyph = 8'b1110_0111;
                    3'd6: glyph = 8'b1111_0111;
                    3'd7: glyph = 8'b1111_1011;
                    default: glyph = 8'b0000_0000;
                endcase
            end
            STEAM:
            begin
                case (row_index)
                    3'd1: glyph = 8'b0000_0001;
                    3'd2: glyph = 8'b1000_0001;
                    3'd3: glyph = 8'b1100_0011;
                    3'd4: glyph = 8'b1000_0011;
                    3'd5: glyph = 8'b1100_0111;
                    3'd6: glyph = 8'b1110_0111;
                    3'd7: glyph = 8'b1111_0011;
                    default: glyph = 8'b0000_0000;
                endcase
            end
            WARN:
            begin
                case (row_index)
                    3'd1: glyph = 8'b0011_1000;
                    3'd2: glyph = 8'b0100_0100;
                    3'd3: glyph = 8'b0101_1010;
                    3'd4: glyph = 8'b0100_1010;
                    3'd5: glyph = 8'b0011_0010;
                    3'd6: glyph = 8'b1100_0100;
                    3'd7: glyph = 8'b0011_1000;
                    default: glyph = 8'b0000_0000;
                endcase
            end
            LID:
            begin
                case (row_index)
                    3'd2: glyph = 8'b0110_0000;
                    3'd3: glyph = 8'b1111_1100;
                    3'd4: glyph = 8'b0011_1111;
                    3'd5: glyph = 8'b0011_1110;
                    3'd6: glyph = 8'b0001_1100;
                    default: glyph = 8'b0000_0000;
                endcase
            end
            BELL:
            begin
                case (row_index)
                    3'd2:       glyph = 8'b0001_1000;
                    3'd3:       glyph = 8'b0011_1100;
                    3'd4, 3'd5: glyph = 8'b0111_1110;
                    3'd6:       glyph = 8'b0010_0100; // clapper
                    default:    glyph = 8'b0000_0000;
                endcase
            end
            FAULT_ICON:
            begin
                case (row_index)
                    3'd0: glyph = 8'b1110_0000;
                    3'd1: glyph = 8'b0110_0000;
                    3'd2: glyph = 8'b1110_0000;
                    3'd3: glyph = 8'b0011_0000;
                    3'd4: glyph = 8'b0011_0001;
                    3'd5: glyph = 8'b0011_0011;
                    3'd6: glyph = 8'b0011_1110;
                    3'd7: glyph = 8'b0001_1100;
                    default: glyph = 8'b0000_0000;
                endcase
            end
            default:
            begin
                glyph = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/heater_panel_top.sv
`default_nettype none
`timescale 1ns/1ps

module heater_panel_top import panel_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     st,
    input  logic                     temp,
    input  logic [HEAT_LEVEL_W-1:0]  heat_level,
    input  icon_req_t                icon_req,
    input  logic                     fault,
    output logic [ROWS-1:0]          row,
    output logic [COLS-1:0]          colr,
    output logic [COLS-1:0]          colg
);

    frame_id_t  frame; // sequencer to scanner

    stage_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .temp       (temp),
        .heat_level (heat_level),
        .icon_req   (icon_req),
        .fault      (fault),
        .frame      (frame)
    );

    // temp also feeds the scanner directly for the red rule
    matrix_scan u_scan (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .temp  (temp),
        .frame (frame),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

`default_nettype wire

// File: hw/matrix_scan.sv
`default_nettype none
`timescale 1ns/1ps

module matrix_scan import panel_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             st,
    input  logic             temp,
    input  frame_id_t        frame,
    output logic [ROWS-1:0]  row,
    output logic [COLS-1:0]  colr,
    output logic [COLS-1:0]  colg
);

    frame_id_t         disp_frame;
    logic [2:0]        row_idx;
    logic [COLS-1:0]   glyph;
    logic              red_on;

    glyph_rom u_rom (
        .frame     (disp_frame),
        .row_index (row_idx),
        .glyph     (glyph)
    );

    // orange under over-temperature, alert icons always red
    assign red_on = temp || (disp_frame inside {STEAM, LID, FAULT_ICON});

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            disp_frame <= FLAME_0;
            row_idx    <= 3'd0;
        end
        else if (!st)
        begin
            disp_frame <= FLAME_0;
            row_idx    <= 3'd0; // next scan starts at row 0
        end
        else
        begin
            disp_frame <= frame;
            row_idx    <= row_idx + 3'd1; // wraps 7 -> 0
        end
    end

    // row strobe and both column buses move together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else if (!st)
        begin
            row  <= '1; // panel blank
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= ~(ROWS'(1) << row_idx);
            colg <= glyph;
            colr <= red_on ? glyph : '0;
        end
    end

    // one row driven once the scan has run a clock
    a_one_row: assert property (@(posedge clk) disable iff (rst)
        $past(st && !rst) |-> $countones(~row) == 1);

    a_blank: assert property (@(posedge clk) disable iff (rst)
        !$past(st) |-> (row == '1 && colg == '0 && colr == '0));

    // red never lights a dot that green leaves off
    a_red_in_green: assert property (@(posedge clk) disable iff (rst)
        (colr & ~colg) == '0);

endmodule

`default_nettype wire

// File: hw/panel_pkg.sv
`default_nettype none

package panel_pkg;

    // panel geometry
    localparam int ROWS = 8;
    localparam int COLS = 8;

    localparam int FRAME_COUNT = 12;

    // input widths
    localparam int HEAT_LEVEL_W = 3;
    localparam int ICON_REQ_W = 3;

    // glyph numbers, matching the rom table order
    typedef enum logic [3:0] {
        FLAME_0    = 4'd0,
        FLAME_1    = 4'd1,
        FLAME_2    = 4'd2,
        FLAME_3    = 4'd3,
        FLAME_4    = 4'd4,
        FLAME_FULL = 4'd5,
        FAN        = 4'd6,
        STEAM      = 4'd7,
        WARN       = 4'd8,
        LID        = 4'd9,
        BELL       = 4'd10,
        FAULT_ICON = 4'd11
    } frame_id_t;

    // 5..7 are treated as no request
    typedef enum logic [ICON_REQ_W-1:0] {
        ICON_NONE  = 3'd0,
        ICON_FAN   = 3'd1,
        ICON_STEAM = 3'd2,
        ICON_LID   = 3'd3,
        ICON_BELL  = 3'd4
    } icon_req_t;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        HEAT     = 2'd1,
        OVERTEMP = 2'd2,
        FAULT    = 2'd3
    } seq_state_t;

endpackage

`default_nettype wire

// File: hw/stage_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module stage_sequencer import panel_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     st,
    input  logic                     temp,
    input  logic [HEAT_LEVEL_W-1:0]  heat_level,
    input  icon_req_t                icon_req,
    input  logic                     fault,
    output frame_id_t                frame
);

    seq_state_t  state;
    seq_state_t  state_next;
    frame_id_t   heat_frame;
    frame_id_t   frame_next;

    // levels above the flame steps saturate
    assign heat_frame = (heat_level > 3'd5) ? FLAME_FULL : frame_id_t'({1'b0, heat_level});

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:     if (st) state_next = HEAT;
            HEAT:
            begin
                if (fault)
                    state_next = FAULT;
                else if (temp)
                    state_next = OVERTEMP;
            end
            OVERTEMP:
            begin
                if (fault)
                    state_next = FAULT;
                else if (!temp)
                    state_next = HEAT;
            end
            FAULT:    state_next = FAULT; // held until st drops
            default:  state_next = IDLE;
        endcase
        if (!st)
            state_next = IDLE;
    end

    // frame follows the state being entered
    always_comb
    begin
        case (state_next)
            OVERTEMP: frame_next = WARN;
            FAULT:    frame_next = FAULT_ICON;
            HEAT:
            begin
                case (icon_req)
                    ICON_FAN:   frame_next = FAN;
                    ICON_STEAM: frame_next = STEAM;
                    ICON_LID:   frame_next = LID;
                    ICON_BELL:  frame_next = BELL;
                    default:    frame_next = heat_frame;
                endcase
            end
            default:  frame_next = FLAME_0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
            frame <= FLAME_0;
        end
        else
        begin
            state <= state_next;
            frame <= frame_next;
        end
    end

    a_frame_range: assert property (@(posedge clk) disable iff (rst)
        frame < FRAME_COUNT);

    // fault clears only by going back to idle
    a_fault_exit: assert property (@(posedge clk) disable iff (rst)
        state == FAULT |=> state inside {FAULT, IDLE});

endmodule

`default_nettype wire

// File: tb.f
hw/panel_pkg.sv
hw/glyph_rom.sv
hw/matrix_scan.sv
hw/stage_sequencer.sv
hw/heater_panel_top.sv
verification/tb_clock.sv
verification/heater_panel_tb.sv

// File: verification/heater_panel_tb.sv
`default_nettype none
`timescale 1ns/1ps

module heater_panel_tb import panel_pkg::*; ();

    logic                     clk;
    logic                     rst;
    logic                     st;
    logic                     temp;
    logic [HEAT_LEVEL_W-1:0]  heat_level;
    icon_req_t                icon_req;
    logic                     fault;
    logic [ROWS-1:0]          row;
    logic [COLS-1:0]          colr;
    logic [COLS-1:0]          colg;

    int errors;
    int timeouts;

    tb_clock u_clk (
        .clk (clk)
    );

    heater_panel_top uut (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .temp       (temp),
        .heat_level (heat_level),
        .icon_req   (icon_req),
        .fault      (fault),
        .row        (row),
        .colr       (colr),
        .colg       (colg)
    );

    // reference glyphs, row 0 in the top byte
    function automatic logic [63:0] glyph_rows(input frame_id_t f);
        case (f)
            FLAME_0:    return 64'h0000_183C_3C18_0000;
            FLAME_1:    return 64'h0000_387C_7C38_0000;
            FLAME_2:    return 64'h0000_3C7E_7E3C_0000;
            FLAME_3:    return 64'h003C_7E7E_7E7E_3C00;
            FLAME_4:    return 64'h3C7E_FFFF_FFFF_7E3C;
            FLAME_FULL: return 64'hFFFF_FFFF_FFFF_FFFF;
            FAN:        return 64'hC3E3_F1E3_C7E7_F7FB;
            STEAM:      return 64'h0001_81C3_83C7_E7F3;
            WARN:       return 64'h0038_445A_4A32_C438;
            LID:        return 64'h0000_60FC_3F3E_1C00;
            BELL:       return 64'h0000_183C_7E7E_2400;
            FAULT_ICON: return 64'hE060_E030_3133_3E1C;
            default:    return 64'h0;
        endcase
    endfunction

    function automatic logic [7:0] glyph_row(input frame_id_t f, input int r);
        logic [63:0] rows;
        rows = glyph_rows(f);
        return rows[8*(7-r) +: 8];
    endfunction

    function automatic frame_id_t flame_for_level(input int lvl);
        case (lvl)
            0:       return FLAME_0;
            1:       return FLAME_1;
            2:       return FLAME_2;
            3:       return FLAME_3;
            4:       return FLAME_4;
            default: return FLAME_FULL; // 5..7 saturate
        endcase
    endfunction

    function automatic frame_id_t icon_frame(input icon_req_t ic);
        case (ic)
            ICON_FAN:   return FAN;
            ICON_STEAM: return STEAM;
            ICON_LID:   return LID;
            default:    return BELL;
        endcase
    endfunction

    // red follows temp and the three alert icons
    function automatic logic red_expected(input frame_id_t f, input logic t);
        return t || f == STEAM || f == LID || f == FAULT_ICON;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic wait_for_row(input logic [7:0] pattern, output bit found);
        int n;
        found = 0;
        n = 0;
        while (!found && n < 20)
        begin
            @(negedge clk);
            if (row === pattern)
                found = 1;
            n++;
        end
        if (!found)
        begin
            timeouts++;
            $display("timeout at %0t: row pattern %b not seen within 20 clocks", $time, pattern);
        end
    endtask

    task automatic check_blank(input int cycles, input string what);
        int i;
        for (i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            if (row !== 8'hFF || colg !== 8'h00 || colr !== 8'h00)
                flag_error($sformatf("%s: panel not blank, row=%b colg=%h colr=%h",
                    what, row, colg, colr));
        end
    endtask

    task automatic first_driven_row(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (row === 8'hFF && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (row === 8'hFF)
        begin
            timeouts++;
            $display("timeout at %0t: %s, no row driven within 20 clocks", $time, what);
        end
        else if (row !== 8'hFE)
            flag_error($sformatf("%s: first driven row is %b, not row 0", what, row));
    endtask

    // a new frame reaches the columns within one scan plus three clocks
    task automatic settle();
        repeat (ROWS + 3) @(posedge clk);
    endtask

    task automatic check_scan(input frame_id_t f, input string what);
        bit found;
        int r;
        logic [7:0] exp_row;
        logic [7:0] exp_g;
        logic [7:0] exp_r;
        wait_for_row(8'hFE, found);
        if (found)
        begin
            for (r = 0; r < ROWS; r++)
            begin
                if (r > 0)
                    @(negedge clk);
                exp_row = ~(8'h01 << r);
                exp_g = glyph_row(f, r);
                exp_r = red_expected(f, temp) ? exp_g : 8'h00;
                if (row !== exp_row)
                    flag_error($sformatf("%s: row %0d strobe %b, expected %b",
                        what, r, row, exp_row));
                if (colg !== exp_g)
                    flag_error($sformatf("%s: %s row %0d colg %h, expected %h",
                        what, f.name(), r, colg, exp_g));
                if (colr !== exp_r)
                    flag_error($sformatf("%s: %s row %0d colr %h, expected %h",
                        what, f.name(), r, colr, exp_r));
            end
        end
    endtask

    task automatic reset_and_blanking();
        check_blank(8, "after reset");
        @(posedge clk);
        st <= 1'b1;
        first_driven_row("st raised after reset");
        repeat (3) @(posedge clk);
        st <= 1'b0; // drop mid-scan
        @(posedge clk);
        check_blank(8, "after st fell");
        @(posedge clk);
        st <= 1'b1;
        first_driven_row("st raised again");
    endtask

    task automatic row_walk();
        bit found;
        int i;
        logic [7:0] exp_row;
        wait_for_row(8'hFE, found);
        if (found)
        begin
            for (i = 0; i < 24; i++)
            begin
                if (i > 0)
                    @(negedge clk);
                exp_row = ~(8'h01 << (i % ROWS));
                if (row !== exp_row)
                    flag_error($sformatf("row walk step %0d: row %b, expected %b",
                        i, row, exp_row));
            end
        end
    endtask

    task automatic heat_level_frames();
        int levels[8];
        int i;
        for (i = 0; i < 5; i++)
            levels[i] = $urandom % 8;
        levels[5] = 5;
        levels[6] = 6;
        levels[7] = 7;
        for (i = 0; i < 8; i++)
        begin
            @(posedge clk);
            heat_level <= levels[i][2:0];
            icon_req   <= ICON_NONE;
            temp       <= 1'b0;
            settle();
            check_scan(flame_for_level(levels[i]), $sformatf("heat level %0d", levels[i]));
        end
    endtask

    task automatic icon_frames();
        icon_req_t order[4];
        icon_req_t tmp;
        int i;
        int j;
        order[0] = ICON_FAN;
        order[1] = ICON_STEAM;
        order[2] = ICON_LID;
        order[3] = ICON_BELL;
        for (i = 3; i > 0; i--)
        begin
            j = $urandom % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < 4; i++)
        begin
            @(posedge clk);
            icon_req <= order[i];
            settle();
            check_scan(icon_frame(order[i]), $sformatf("icon %s", order[i].name()));
        end
        @(posedge clk);
        icon_req <= ICON_NONE;
    endtask

    task automatic overtemp_warning();
        @(posedge clk);
        heat_level <= 3'd3;
        temp       <= 1'b1;
        settle();
        check_scan(WARN, "over-temperature");
        @(posedge clk);
        temp <= 1'b0;
        settle();
        check_scan(FLAME_3, "temperature back to normal");
    endtask

    task automatic fault_latching();
        @(posedge clk);
        heat_level <= 3'd2;
        fault      <= 1'b1;
        @(posedge clk);
        fault <= 1'b0; // single-cycle pulse
        settle();
        check_scan(FAULT_ICON, "fault pulse");
        @(posedge clk);
        heat_level <= 3'd4;
        icon_req   <= ICON_BELL;
        settle();
        check_scan(FAULT_ICON, "fault held over heat and icon change");
        @(posedge clk);
        icon_req <= ICON_NONE;
        st       <= 1'b0;
        @(posedge clk);
        st <= 1'b1;
        settle();
        check_scan(FLAME_4, "fault cleared by st");
    endtask

    initial
    begin
        errors     = 0;
        timeouts   = 0;
        rst        = 1'b1;
        st         = 1'b0;
        temp       = 1'b0;
        heat_level = '0;
        icon_req   = ICON_NONE;
        fault      = 1'b0;
        void'($urandom(2593));
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_and_blanking();
        row_walk();
        heat_level_frames();
        icon_frames();
        overtemp_warning();
        fault_latching();
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam realtime HALF_PERIOD = 50ns; // 100 ns period

    initial
    begin
        clk = 1'b0;
    end

    always
    begin
        #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire
